// ==== Makefile ====
TOP := tb_lsu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== dv/lsu_vectors.svh ====
`ifndef LSU_VECTORS_SVH
`define LSU_VECTORS_SVH

// columns: store, funct3, src1, imm, src2, expected resp_data, expected resp_err
typedef struct packed {
	logic        store;
	logic [2:0]  funct3;
	logic [31:0] src1;
	logic [31:0] imm;
	logic [31:0] src2;
	logic [31:0] exp_data;
	logic        exp_err;
} vec_t;

localparam int num_vectors = 31;

localparam vec_t vectors [num_vectors] = '{
	'{1'b1, 3'd2, 32'h0000_0100, 32'h0000_0000, 32'hdead_beef, 32'h0000_0000, 1'b0}, // sw
	'{1'b0, 3'd2, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000, 32'hdead_beef, 1'b0}, // lw
	// sb at each offset, junk above the low byte must not land
	'{1'b1, 3'd0, 32'h0000_0104, 32'h0000_0000, 32'hffff_ff11, 32'h0000_0000, 1'b0},
	'{1'b1, 3'd0, 32'h0000_0104, 32'h0000_0001, 32'hffff_ff22, 32'h0000_0000, 1'b0},
	'{1'b1, 3'd0, 32'h0000_0104, 32'h0000_0002, 32'hffff_ff33, 32'h0000_0000, 1'b0},
	'{1'b1, 3'd0, 32'h0000_0104, 32'h0000_0003, 32'hffff_ff44, 32'h0000_0000, 1'b0},
	'{1'b0, 3'd2, 32'h0000_0104, 32'h0000_0000, 32'h0000_0000, 32'h4433_2211, 1'b0},
	// sh, aligned then misaligned lanes that drop off the top
	'{1'b1, 3'd1, 32'h0000_0108, 32'h0000_0000, 32'haaaa_5566, 32'h0000_0000, 1'b0},
	'{1'b1, 3'd1, 32'h0000_0108, 32'h0000_0002, 32'h1234_7788, 32'h0000_0000, 1'b0},
	'{1'b0, 3'd2, 32'h0000_0108, 32'h0000_0000, 32'h0000_0000, 32'h7788_5566, 1'b0},
	'{1'b1, 3'd1, 32'h0000_010c, 32'h0000_0001, 32'h0000_beef, 32'h0000_0000, 1'b0},
	'{1'b1, 3'd1, 32'h0000_010c, 32'h0000_0003, 32'h0000_cafe, 32'h0000_0000, 1'b0},
	'{1'b0, 3'd2, 32'h0000_010c, 32'h0000_0000, 32'h0000_0000, 32'hfebe_ef00, 1'b0},
	// sw to 0x110 through a negative imm, then loads through base 0x100
	'{1'b1, 3'd2, 32'h0000_0200, 32'hffff_ff10, 32'h80f2_7fa5, 32'h0000_0000, 1'b0},
	'{1'b0, 3'd0, 32'h0000_0100, 32'h0000_0010, 32'h0000_0000, 32'hffff_ffa5, 1'b0}, // lb
	'{1'b0, 3'd0, 32'h0000_0100, 32'h0000_0011, 32'h0000_0000, 32'h0000_007f, 1'b0},
	'{1'b0, 3'd0, 32'h0000_0100, 32'h0000_0012, 32'h0000_0000, 32'hffff_fff2, 1'b0},
	'{1'b0, 3'd0, 32'h0000_0100, 32'h0000_0013, 32'h0000_0000, 32'hffff_ff80, 1'b0},
	'{1'b0, 3'd4, 32'h0000_0100, 32'h0000_0010, 32'h0000_0000, 32'h0000_00a5, 1'b0}, // lbu
	'{1'b0, 3'd4, 32'h0000_0100, 32'h0000_0011, 32'h0000_0000, 32'h0000_007f, 1'b0},
	'{1'b0, 3'd4, 32'h0000_0100, 32'h0000_0012, 32'h0000_0000, 32'h0000_00f2, 1'b0},
	'{1'b0, 3'd4, 32'h0000_0100, 32'h0000_0013, 32'h0000_0000, 32'h0000_0080, 1'b0},
	'{1'b0, 3'd1, 32'h0000_0100, 32'h0000_0010, 32'h0000_0000, 32'h0000_7fa5, 1'b0}, // lh
	'{1'b0, 3'd1, 32'h0000_0100, 32'h0000_0012, 32'h0000_0000, 32'hffff_80f2, 1'b0},
	'{1'b0, 3'd5, 32'h0000_0100, 32'h0000_0010, 32'h0000_0000, 32'h0000_7fa5, 1'b0}, // lhu
	'{1'b0, 3'd5, 32'h0000_0100, 32'h0000_0012, 32'h0000_0000, 32'h0000_80f2, 1'b0},
	'{1'b0, 3'd2, 32'h0000_0120, 32'hffff_fff0, 32'h0000_0000, 32'h80f2_7fa5, 1'b0},
	// out of range, 0x400 aliases word 0 which must stay zero
	'{1'b1, 3'd2, 32'h0000_03fc, 32'h0000_0004, 32'h1234_5678, 32'h0000_0000, 1'b1},
	'{1'b0, 3'd2, 32'h0000_0400, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
	'{1'b0, 3'd4, 32'h0000_0500, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
	'{1'b0, 3'd2, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0}
};

`endif

// ==== dv/tb_lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

	localparam int wait_limit = 100;

	logic        clock;
	logic        reset;
	logic        req_valid;
	logic        req_ready;
	logic        req_store;
	logic [2:0]  req_funct3;
	logic [31:0] req_src1;
	logic [31:0] req_src2;
	logic [31:0] req_imm;
	logic        resp_valid;
	logic        resp_ready;
	logic [31:0] resp_data;
	logic        resp_err;

	int          errors;
	int          timeouts;
	logic [15:0] lfsr;

	`include "lsu_vectors.svh"

	lsu_top uut (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_store  (req_store),
		.req_funct3 (req_funct3),
		.req_src1   (req_src1),
		.req_src2   (req_src2),
		.req_imm    (req_imm),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_data  (resp_data),
		.resp_err   (resp_err)
	);

	always #10 clock = ~clock;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			value = value * 2 + (lfsr[0] ? 1 : 0);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request and response handshakes

	task automatic send_request(input int i, output bit ok);
		int cycles;
		cycles     = 0;
		req_valid  = 1'b1;
		req_store  = vectors[i].store;
		req_funct3 = vectors[i].funct3;
		req_src1   = vectors[i].src1;
		req_imm    = vectors[i].imm;
		req_src2   = vectors[i].src2;
		while (!req_ready && cycles < wait_limit) begin
			@(posedge clock);
			#2;
			cycles++;
		end
		ok = req_ready;
		if (!ok)
			$display("request %0d was not accepted within %0d cycles", i, wait_limit);
		@(posedge clock);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic collect_response(input int i, output bit ok);
		int cycles;
		int hold;
		cycles = 0;
		draw_bits(3, hold);
		while (!resp_valid && cycles < wait_limit) begin
			@(posedge clock);
			#2;
			cycles++;
		end
		ok = resp_valid;
		if (!ok) begin
			$display("no response to request %0d within %0d cycles", i, wait_limit);
		end else begin
			check_value("resp_data", resp_data, vectors[i].exp_data);
			check_value("resp_err", 32'(resp_err), 32'(vectors[i].exp_err));
			check_value("req_ready", 32'(req_ready), 32'd0);
			// response must hold while resp_ready stays low
			repeat (hold) begin
				@(posedge clock);
				#2;
				check_value("resp_valid", 32'(resp_valid), 32'd1);
				check_value("resp_data", resp_data, vectors[i].exp_data);
				check_value("resp_err", 32'(resp_err), 32'(vectors[i].exp_err));
				check_value("req_ready", 32'(req_ready), 32'd0);
			end
			resp_ready = 1'b1;
			@(posedge clock);
			#2;
			resp_ready = 1'b0;
			check_value("resp_valid", 32'(resp_valid), 32'd0);
		end
	endtask

	initial begin
		bit ok;
		clock      = 1'b0;
		reset      = 1'b1;
		req_valid  = 1'b0;
		req_store  = 1'b0;
		req_funct3 = 3'd0;
		req_src1   = 32'd0;
		req_src2   = 32'd0;
		req_imm    = 32'd0;
		resp_ready = 1'b0;
		errors     = 0;
		timeouts   = 0;
		lfsr       = 16'd61896;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;
		check_value("req_ready", 32'(req_ready), 32'd1);
		check_value("resp_valid", 32'(resp_valid), 32'd0);
		for (int i = 0; i < num_vectors; i++) begin
			send_request(i, ok);
			if (ok)
				collect_response(i, ok);
			if (!ok) begin
				timeouts++;
				break;
			end
		end
		$display("%0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
+incdir+dv
verilog/lsu_pkg.sv
verilog/wait_timer.sv
verilog/lsu_ctrl.sv
verilog/lsu_datapath.sv
verilog/axi_sram.sv
verilog/lsu_top.sv
dv/tb_lsu_top.sv

// ==== verilog/axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module axi_sram (
	input  wire                    clock,
	input  wire                    reset,
	input  wire  [`LSU_XLEN-1:0]   araddr,
	input  wire                    arvalid,
	output logic                   arready,
	output logic [`LSU_XLEN-1:0]   rdata,
	output lsu_pkg::bus_resp_t     rresp,
	output logic                   rvalid,
	input  wire                    rready,
	input  wire  [`LSU_XLEN-1:0]   awaddr,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire  [`LSU_XLEN-1:0]   wdata,
	input  wire  [`LSU_XLEN/8-1:0] wstrb,
	input  wire                    wvalid,
	output logic                   wready,
	output lsu_pkg::bus_resp_t     bresp,
	output logic                   bvalid,
	input  wire                    bready
);
	import lsu_pkg::*;

	localparam int IDX_W = $clog2(`SRAM_WORDS);

	typedef enum logic [1:0] {SRAM_IDLE, SRAM_BUSY, SRAM_RESP} sram_state_t;

	sram_state_t            state;
	logic [`LSU_XLEN-1:0]   mem [`SRAM_WORDS];
	logic [`LSU_XLEN-1:0]   addr_q;
	logic [`LSU_XLEN-1:0]   wdata_q;
	logic [`LSU_XLEN/8-1:0] wstrb_q;
	logic                   write_q;
	logic                   rd_hs;
	logic                   wr_hs;
	logic                   timer_done;
	logic                   finish;
	logic                   in_range;
	logic [IDX_W-1:0]       idx;

	// reads win if both channels show up together
	assign arready  = (state == SRAM_IDLE);
	assign awready  = (state == SRAM_IDLE) && !arvalid && awvalid && wvalid;
	assign wready   = awready;
	assign rd_hs    = arvalid && arready;
	assign wr_hs    = awvalid && awready;
	assign finish   = (state == SRAM_BUSY) && timer_done;
	assign in_range = (addr_q < `SRAM_LIMIT);
	assign idx      = addr_q[IDX_W+1:2];

	wait_timer u_timer (
		.clock (clock),
		.reset (reset),
		.start (rd_hs || wr_hs),
		.count (4'(`SRAM_LATENCY)),
		.done  (timer_done)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= SRAM_IDLE;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			case (state)
				SRAM_IDLE: if (rd_hs || wr_hs) state <= SRAM_BUSY;
				SRAM_BUSY: if (timer_done) begin
					state  <= SRAM_RESP;
					rvalid <= !write_q;
					bvalid <= write_q;
				end
				SRAM_RESP: if ((rvalid && rready) || (bvalid && bready)) begin
					state  <= SRAM_IDLE;
					rvalid <= 1'b0;
					bvalid <= 1'b0;
				end
				default: state <= SRAM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rd_hs || wr_hs) begin
			addr_q  <= rd_hs ? araddr : awaddr;
			write_q <= wr_hs;
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		if (finish) begin
			rdata <= in_range ? mem[idx] : '0;
			rresp <= in_range ? RESP_OKAY : RESP_SLVERR;
			bresp <= in_range ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word array, byte lanes under wstrb

	initial begin
		for (int i = 0; i < `SRAM_WORDS; i++)
			mem[i] = '0;
	end

	always @(posedge clock) begin
		if (finish && write_q && in_range) begin
			for (int b = 0; b < `LSU_XLEN/8; b++)
				if (wstrb_q[b])
					mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
		end
	end

	a_latency: assert property (@(posedge clock) disable iff (reset)
		(rd_hs || wr_hs) |=> !(rvalid || bvalid) [*`SRAM_LATENCY] ##1 (rvalid || bvalid))
		else $error("axi_sram: response not exactly SRAM_LATENCY after address");

endmodule

`default_nettype wire

// ==== verilog/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 32

// sram depth in 32-bit words
`define SRAM_WORDS 256

// cycles from an accepted address to its response
`define SRAM_LATENCY 3

// byte addresses at or above this get SLVERR
`define SRAM_LIMIT (4 * `SRAM_WORDS)

`endif

// ==== verilog/lsu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     req_valid,
	input  wire                     req_store,
	output logic                    req_ready,
	output logic                    capture,
	output logic                    load_result,
	output logic                    arvalid,
	input  wire                     arready,
	input  wire                     rvalid,
	input  wire lsu_pkg::bus_resp_t rresp,
	output logic                    rready,
	output logic                    awvalid,
	input  wire                     awready,
	output logic                    wvalid,
	input  wire                     wready,
	input  wire                     bvalid,
	input  wire lsu_pkg::bus_resp_t bresp,
	output logic                    bready,
	output logic                    resp_valid,
	input  wire                     resp_ready,
	output logic                    resp_err
);
	import lsu_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_ADDR,
		S_RD_WAIT,
		S_WR_ISSUE,
		S_WR_WAIT,
		S_RESP
	} state_t;

	state_t state;
	state_t state_next;

	assign req_ready   = (state == S_IDLE);
	assign capture     = req_valid & req_ready;
	assign arvalid     = (state == S_RD_ADDR);
	assign rready      = (state == S_RD_WAIT);
	assign bready      = (state == S_WR_WAIT);
	assign resp_valid  = (state == S_RESP);
	assign load_result = rvalid & rready;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:     if (capture) state_next = req_store ? S_WR_ISSUE : S_RD_ADDR;
			S_RD_ADDR:  if (arready) state_next = S_RD_WAIT;
			S_RD_WAIT:  if (rvalid) state_next = S_RESP;
			// leave once aw and w have both gone through in either order
			S_WR_ISSUE: if ((!awvalid || awready) && (!wvalid || wready)) state_next = S_WR_WAIT;
			S_WR_WAIT:  if (bvalid) state_next = S_RESP;
			S_RESP:     if (resp_ready) state_next = S_IDLE;
			default:    state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= S_IDLE;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			resp_err <= 1'b0;
		end else begin
			state   <= state_next;
			awvalid <= awvalid ? !awready : (capture && req_store);
			wvalid  <= wvalid ? !wready : (capture && req_store);
			if (load_result)
				resp_err <= (rresp != RESP_OKAY);
			else if (bvalid && bready)
				resp_err <= (bresp != RESP_OKAY);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// protocol checks

	a_arvalid_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid)
		else $error("lsu_ctrl: arvalid dropped before arready");

	a_one_in_flight: assert property (@(posedge clock) disable iff (reset)
		req_ready |-> !resp_valid && !awvalid && !wvalid)
		else $error("lsu_ctrl: request port open with a transaction pending");

endmodule

`default_nettype wire

// ==== verilog/lsu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_datapath (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    capture,
	input  wire                    load_result,
	input  wire                    req_store,
	input  wire  [2:0]             req_funct3,
	input  wire  [`LSU_XLEN-1:0]   req_src1,
	input  wire  [`LSU_XLEN-1:0]   req_src2,
	input  wire  [`LSU_XLEN-1:0]   req_imm,
	input  wire  [`LSU_XLEN-1:0]   rdata,
	output logic [`LSU_XLEN-1:0]   araddr,
	output logic [`LSU_XLEN-1:0]   awaddr,
	output logic [2:0]             arsize,
	output logic [2:0]             awsize,
	output logic [`LSU_XLEN-1:0]   wdata,
	output logic [`LSU_XLEN/8-1:0] wstrb,
	output logic [`LSU_XLEN-1:0]   resp_data
);
	import lsu_pkg::*;

	logic [`LSU_XLEN-1:0]   addr_q;
	logic [`LSU_XLEN-1:0]   data_q;
	logic [2:0]             funct3_q;
	logic                   store_q;
	mem_width_t             width;
	logic [`LSU_XLEN/8-1:0] wmask;
	logic [4:0]             bit_off;
	logic [`LSU_XLEN-1:0]   rshift;
	logic [`LSU_XLEN-1:0]   ext;

	// held for the whole bus transaction
	always_ff @(posedge clock) begin
		if (capture) begin
			addr_q   <= req_src1 + req_imm;
			data_q   <= req_src2;
			funct3_q <= req_funct3;
			store_q  <= req_store;
		end
	end

	assign width   = mem_width_t'(funct3_q[1:0]);
	assign bit_off = {addr_q[1:0], 3'b000};
	assign araddr  = addr_q;
	assign awaddr  = addr_q;
	assign arsize  = {1'b0, width};
	assign awsize  = {1'b0, width};

	always_comb begin
		case (width)
			MEM_BYTE: wmask = 4'b0001;
			MEM_HALF: wmask = 4'b0011;
			MEM_WORD: wmask = 4'b1111;
			default:  wmask = 4'b0000;
		endcase
	end

	// misaligned lanes fall off the top of the word
	assign wstrb  = wmask << addr_q[1:0];
	assign wdata  = data_q << bit_off;
	assign rshift = rdata >> bit_off;

	always_comb begin
		case (funct3_q)
			3'b000:  ext = {{(`LSU_XLEN-8){rshift[7]}}, rshift[7:0]};
			3'b001:  ext = {{(`LSU_XLEN-16){rshift[15]}}, rshift[15:0]};
			3'b010:  ext = rshift;
			3'b100:  ext = {{(`LSU_XLEN-8){1'b0}}, rshift[7:0]};
			3'b101:  ext = {{(`LSU_XLEN-16){1'b0}}, rshift[15:0]};
			default: ext = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			resp_data <= '0;
		else if (capture && req_store)
			resp_data <= '0;
		else if (load_result)
			resp_data <= ext;
	end

	a_funct3_legal: assert property (@(posedge clock) disable iff (reset)
		capture |=> (store_q ? (funct3_q <= 3'd2) : (funct3_q != 3'd3 && funct3_q <= 3'd5)))
		else $error("lsu_datapath: illegal funct3 %0d", funct3_q);

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	// access width, taken straight from funct3[1:0]
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_width_t;

	// AXI response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} bus_resp_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  req_valid,
	output wire                  req_ready,
	input  wire                  req_store,
	input  wire [2:0]            req_funct3,
	input  wire [`LSU_XLEN-1:0]  req_src1,
	input  wire [`LSU_XLEN-1:0]  req_src2,
	input  wire [`LSU_XLEN-1:0]  req_imm,
	output wire                  resp_valid,
	input  wire                  resp_ready,
	output wire [`LSU_XLEN-1:0]  resp_data,
	output wire                  resp_err
);
	import lsu_pkg::*;

	logic                   capture;
	logic                   load_result;

	// bus between the LSU and the sram
	logic [`LSU_XLEN-1:0]   araddr;
	logic                   arvalid;
	logic                   arready;
	logic [`LSU_XLEN-1:0]   rdata;
	bus_resp_t              rresp;
	logic                   rvalid;
	logic                   rready;
	logic [`LSU_XLEN-1:0]   awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [`LSU_XLEN-1:0]   wdata;
	logic [`LSU_XLEN/8-1:0] wstrb;
	logic                   wvalid;
	logic                   wready;
	bus_resp_t              bresp;
	logic                   bvalid;
	logic                   bready;

	lsu_ctrl u_ctrl (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_store   (req_store),
		.req_ready   (req_ready),
		.capture     (capture),
		.load_result (load_result),
		.arvalid     (arvalid),
		.arready     (arready),
		.rvalid      (rvalid),
		.rresp       (rresp),
		.rready      (rready),
		.awvalid     (awvalid),
		.awready     (awready),
		.wvalid      (wvalid),
		.wready      (wready),
		.bvalid      (bvalid),
		.bresp       (bresp),
		.bready      (bready),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_err    (resp_err)
	);

	// the word-organised sram takes no access size
	lsu_datapath u_datapath (
		.clock       (clock),
		.reset       (reset),
		.capture     (capture),
		.load_result (load_result),
		.req_store   (req_store),
		.req_funct3  (req_funct3),
		.req_src1    (req_src1),
		.req_src2    (req_src2),
		.req_imm     (req_imm),
		.rdata       (rdata),
		.araddr      (araddr),
		.awaddr      (awaddr),
		.arsize      (),
		.awsize      (),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.resp_data   (resp_data)
	);

	axi_sram u_sram (
		.clock   (clock),
		.reset   (reset),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

`default_nettype wire

// ==== verilog/wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
	input  wire       clock,
	input  wire       reset,
	input  wire       start,
	input  wire [3:0] count,
	output logic      done
);

	logic [3:0] remaining;

	// done lands count edges after start, counting the start edge
	always_ff @(posedge clock) begin
		if (reset) begin
			remaining <= 4'd0;
			done      <= 1'b0;
		end else if (start) begin
			remaining <= count - 4'd1;
			done      <= (count == 4'd1);
		end else begin
			if (remaining != 4'd0)
				remaining <= remaining - 4'd1;
			done <= (remaining == 4'd1);
		end
	end

	a_no_restart: assert property (@(posedge clock) disable iff (reset)
		start |-> (remaining == 4'd0) && !done)
		else $error("wait_timer: start while a count is running");

endmodule

`default_nettype wire
